/* rtl/gfx_clear_counter.sv */
module gfx_clear_counter (
    input  logic                             video_clk,
    input  logic                             reset_n,
    input  logic                             clear,
    input  logic                             step,
    input  logic [gfx_pkg::MEM_ADDR_W-1:0]   page_size,
    output logic [gfx_pkg::MEM_ADDR_W-1:0]   count,     // Byte offset inside the page
    output logic                             last
);

    // ========================================
    // Offset counter
    // ========================================
    always_ff @(posedge video_clk or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

    // Final byte of the page
    assign last = (count == page_size - 1'b1);

endmodule

/* rtl/gfx_cmd_fsm.sv */
module gfx_cmd_fsm (
    input  logic                             video_clk,
    input  logic                             reset_n,
    input  logic [7:0]                       mode_control,
    input  gfx_pkg::cmd_t                    cmd,
    input  logic                             instruction_start,
    output logic                             busy,
    output logic                             finished,
    output logic                             error,
    output gfx_pkg::mem_req_t                mem_req,
    input  logic [gfx_pkg::PIX_W-1:0]        video_data_in,
    output logic [gfx_pkg::PIX_W-1:0]        result_pixel_data,
    // Cursor
    input  logic [gfx_pkg::COORD_W-1:0]      cur_x,
    input  logic [gfx_pkg::COORD_W-1:0]      cur_y,
    output logic                             cur_load,
    output logic                             cur_advance,
    output logic                             cur_home,
    // Clear counter
    output logic                             cnt_clear,
    output logic                             cnt_step,
    input  logic [gfx_pkg::MEM_ADDR_W-1:0]   cnt_count,
    input  logic                             cnt_last,
    // Address and merge
    output logic [gfx_pkg::COORD_W-1:0]      sel_x,
    output logic [gfx_pkg::COORD_W-1:0]      sel_y,
    input  logic [gfx_pkg::MEM_ADDR_W-1:0]   pix_addr,
    input  logic                             in_bounds,
    output logic [gfx_pkg::PIX_W-1:0]        merge_old,
    output logic [gfx_pkg::PIX_W-1:0]        merge_color,
    input  logic [gfx_pkg::PIX_W-1:0]        new_byte,
    input  logic [gfx_pkg::PIX_W-1:0]        pixel
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CHECK,      // Single bounds check, first memory access
        S_RD_WAIT,
        S_RD_HOLD,    // Read address held a second cycle
        S_RD_USE,     // Read byte valid on video_data_in
        S_CLEAR,
        S_FINISH,
        S_FAIL
    } state_e;

    state_e               state;
    gfx_pkg::gfx_opcode_e op;
    logic                 direct;       // 8 bpp, no read-modify-write
    logic                 is_write_op;
    logic                 pix_write;

    // cmd stays stable while busy, so the opcode is decoded live
    assign op     = gfx_pkg::gfx_opcode_e'(cmd.opcode);
    assign direct = (gfx_pkg::gfx_mode_e'(mode_control[2:0]) == gfx_pkg::MODE_320X240_8BPP);
    assign is_write_op = (op == gfx_pkg::OP_WRITE_PIXEL) || (op == gfx_pkg::OP_WRITE_PIXEL_POS);

    // ========================================
    // Coordinate source
    // ========================================
    always_comb begin
        if (op == gfx_pkg::OP_CLEAR_SCREEN) begin
            sel_x = '0;                      // Address of (0,0) is the page base
            sel_y = '0;
        end else if (op == gfx_pkg::OP_WRITE_PIXEL) begin
            sel_x = cur_x;
            sel_y = cur_y;
        end else begin
            sel_x = cmd.x;
            sel_y = cmd.y;
        end
    end

    assign merge_old   = video_data_in;
    assign merge_color = cmd.color;

    // Pixel write issued this cycle
    assign pix_write = is_write_op &&
                       ((state == S_CHECK && in_bounds && direct) || state == S_RD_USE);

    assign cur_advance = pix_write;
    assign cur_load    = (state == S_CHECK && in_bounds && op == gfx_pkg::OP_PIXEL_POS) ||
                         (pix_write && op == gfx_pkg::OP_WRITE_PIXEL_POS);
    assign cur_home    = (state == S_CLEAR) && cnt_last;

    assign cnt_clear = (state == S_IDLE);
    assign cnt_step  = (state == S_CLEAR);

    // ========================================
    // Sequencer
    // ========================================
    always_ff @(posedge video_clk or negedge reset_n) begin
        if (!reset_n) begin
            state             <= S_IDLE;
            busy              <= 1'b0;
            finished          <= 1'b0;
            error             <= 1'b0;
            mem_req           <= '0;
            result_pixel_data <= '0;
        end else begin
            finished   <= 1'b0;
            error      <= 1'b0;
            mem_req.we <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (instruction_start) begin
                        case (op)
                            gfx_pkg::OP_CLEAR_SCREEN: begin
                                busy  <= 1'b1;
                                state <= S_CLEAR;
                            end
                            gfx_pkg::OP_WRITE_PIXEL, gfx_pkg::OP_PIXEL_POS,
                            gfx_pkg::OP_WRITE_PIXEL_POS, gfx_pkg::OP_GET_PIXEL_AT: begin
                                busy  <= 1'b1;
                                state <= S_CHECK;
                            end
                            default: error <= 1'b1;    // Unknown opcode, busy stays low
                        endcase
                    end
                end
                S_CHECK: begin
                    if (!in_bounds) begin
                        state <= S_FAIL;
                    end else if (op == gfx_pkg::OP_PIXEL_POS) begin
                        state <= S_FINISH;             // Cursor loads this cycle
                    end else if (op == gfx_pkg::OP_GET_PIXEL_AT || !direct) begin
                        mem_req.addr <= pix_addr;      // Start of read
                        state        <= S_RD_WAIT;
                    end else begin
                        mem_req <= '{addr: pix_addr, wdata: cmd.color, we: 1'b1};
                        state   <= S_FINISH;
                    end
                end
                S_RD_WAIT: state <= S_RD_HOLD;
                S_RD_HOLD: state <= S_RD_USE;
                S_RD_USE: begin
                    if (op == gfx_pkg::OP_GET_PIXEL_AT) begin
                        result_pixel_data <= pixel;
                        finished          <= 1'b1;
                        busy              <= 1'b0;
                        state             <= S_IDLE;
                    end else begin
                        mem_req <= '{addr: pix_addr, wdata: new_byte, we: 1'b1};
                        state   <= S_FINISH;
                    end
                end
                S_CLEAR: begin
                    // One byte per cycle from the page base
                    mem_req <= '{addr: pix_addr + cnt_count, wdata: cmd.color, we: 1'b1};
                    if (cnt_last) begin
                        state <= S_FINISH;
                    end
                end
                S_FINISH: begin
                    finished <= 1'b1;
                    busy     <= 1'b0;
                    state    <= S_IDLE;
                end
                S_FAIL: begin
                    error <= 1'b1;
                    busy  <= 1'b0;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* rtl/gfx_controller_top.sv */
module gfx_controller_top (
    input  logic                          video_clk,
    input  logic                          reset_n,
    input  logic [7:0]                    mode_control,   // [2:0] mode, [4] working page
    input  gfx_pkg::cmd_t                 cmd,
    input  logic                          instruction_start,
    output logic                          instruction_busy,
    output logic                          instruction_finished,
    output logic                          instruction_error,
    output gfx_pkg::mem_req_t             mem_req,
    input  logic [gfx_pkg::PIX_W-1:0]     video_data_in,
    output logic [gfx_pkg::PIX_W-1:0]     result_pixel_data
);

    gfx_pkg::mode_cfg_t              mode_cfg;
    logic [gfx_pkg::COORD_W-1:0]     cur_x, cur_y;
    logic [gfx_pkg::COORD_W-1:0]     sel_x, sel_y;
    logic                            cur_load, cur_advance, cur_home;
    logic                            cnt_clear, cnt_step, cnt_last;
    logic [gfx_pkg::MEM_ADDR_W-1:0]  cnt_count;
    logic [gfx_pkg::MEM_ADDR_W-1:0]  pix_addr;
    logic [2:0]                      bit_pos;
    logic                            in_bounds;
    logic [gfx_pkg::PIX_W-1:0]       merge_old, merge_color;
    logic [gfx_pkg::PIX_W-1:0]       new_byte, pixel;

    // Single mode table lookup shared by all blocks
    assign mode_cfg = gfx_pkg::lookup_mode_cfg(gfx_pkg::gfx_mode_e'(mode_control[2:0]));

    gfx_cmd_fsm u_fsm (
        .video_clk, .reset_n, .mode_control, .cmd, .instruction_start,
        .busy(instruction_busy), .finished(instruction_finished), .error(instruction_error),
        .mem_req, .video_data_in, .result_pixel_data,
        .cur_x, .cur_y, .cur_load, .cur_advance, .cur_home,
        .cnt_clear, .cnt_step, .cnt_count, .cnt_last,
        .sel_x, .sel_y, .pix_addr, .in_bounds,
        .merge_old, .merge_color, .new_byte, .pixel
    );

    gfx_cursor u_cursor (
        .video_clk, .reset_n, .mode_cfg,
        .load(cur_load), .load_x(cmd.x), .load_y(cmd.y),
        .advance(cur_advance), .home(cur_home),
        .x(cur_x), .y(cur_y)
    );

    gfx_clear_counter u_clear_counter (
        .video_clk, .reset_n, .clear(cnt_clear), .step(cnt_step),
        .page_size(mode_cfg.page_size), .count(cnt_count), .last(cnt_last)
    );

    gfx_pixel_addr u_pixel_addr (
        .mode_cfg, .page(mode_control[4]), .x(sel_x), .y(sel_y),
        .addr(pix_addr), .bit_pos, .in_bounds
    );

    gfx_pixel_merge u_pixel_merge (
        .bits_per_pixel(mode_cfg.bits_per_pixel), .bit_pos,
        .old_byte(merge_old), .color(merge_color), .new_byte, .pixel
    );

endmodule

/* rtl/gfx_cursor.sv */
module gfx_cursor (
    input  logic                          video_clk,
    input  logic                          reset_n,
    input  gfx_pkg::mode_cfg_t            mode_cfg,
    input  logic                          load,
    input  logic [gfx_pkg::COORD_W-1:0]   load_x,
    input  logic [gfx_pkg::COORD_W-1:0]   load_y,
    input  logic                          advance,
    input  logic                          home,
    output logic [gfx_pkg::COORD_W-1:0]   x,
    output logic [gfx_pkg::COORD_W-1:0]   y
);

    logic [gfx_pkg::COORD_W-1:0] base_x, base_y;
    logic [gfx_pkg::COORD_W-1:0] next_x, next_y;

    // Advance starts from the loaded value when both are set
    always_comb begin
        base_x = load ? load_x : x;
        base_y = load ? load_y : y;
        next_x = base_x;
        next_y = base_y;
        if (advance) begin
            if (base_x >= mode_cfg.width - 16'd1) begin
                next_x = '0;                                   // End of line
                if (base_y >= mode_cfg.height - 16'd1) begin
                    next_y = '0;                               // End of screen
                end else begin
                    next_y = base_y + 16'd1;
                end
            end else begin
                next_x = base_x + 16'd1;
            end
        end
    end

    always_ff @(posedge video_clk or negedge reset_n) begin
        if (!reset_n) begin
            x <= '0;
            y <= '0;
        end else if (home) begin
            x <= '0;
            y <= '0;
        end else begin
            x <= next_x;
            y <= next_y;
        end
    end

endmodule

/* rtl/gfx_pixel_addr.sv */
module gfx_pixel_addr (
    input  gfx_pkg::mode_cfg_t                mode_cfg,
    input  logic                              page,       // Working page select
    input  logic [gfx_pkg::COORD_W-1:0]       x,
    input  logic [gfx_pkg::COORD_W-1:0]       y,
    output logic [gfx_pkg::MEM_ADDR_W-1:0]    addr,
    output logic [2:0]                        bit_pos,    // Low bit of the pixel field
    output logic                              in_bounds
);

    logic [31:0]                     pix_index;
    logic [31:0]                     byte_index;
    logic [gfx_pkg::MEM_ADDR_W-1:0]  page_base;

    // Linear pixel number in raster order
    assign pix_index = 32'(y) * 32'(mode_cfg.width) + 32'(x);

    // Pixels are packed MSB first, so pixel 0 sits in the top bits
    always_comb begin
        case (mode_cfg.bits_per_pixel)
            4'd1: begin
                byte_index = pix_index >> 3;
                bit_pos    = 3'd7 - pix_index[2:0];
            end
            4'd2: begin
                byte_index = pix_index >> 2;
                bit_pos    = {~pix_index[1:0], 1'b0};    // 6, 4, 2, 0
            end
            4'd4: begin
                byte_index = pix_index >> 1;
                bit_pos    = {~pix_index[0], 2'b00};     // Even pixel in high nibble
            end
            default: begin
                byte_index = pix_index;                  // One pixel per byte
                bit_pos    = 3'd0;
            end
        endcase
    end

    assign page_base = (mode_cfg.has_pages && page) ? mode_cfg.page_size : '0;

    assign addr = page_base + byte_index[gfx_pkg::MEM_ADDR_W-1:0];

    assign in_bounds = (x < mode_cfg.width) && (y < mode_cfg.height);

endmodule

/* rtl/gfx_pixel_merge.sv */
module gfx_pixel_merge (
    input  logic [3:0]                  bits_per_pixel,
    input  logic [2:0]                  bit_pos,
    input  logic [gfx_pkg::PIX_W-1:0]   old_byte,
    input  logic [gfx_pkg::PIX_W-1:0]   color,
    output logic [gfx_pkg::PIX_W-1:0]   new_byte,
    output logic [gfx_pkg::PIX_W-1:0]   pixel
);

    logic [gfx_pkg::PIX_W-1:0] field;     // Right-aligned mask of one pixel
    logic [gfx_pkg::PIX_W-1:0] mask;      // Same mask at the pixel position

    always_comb begin
        case (bits_per_pixel)
            4'd1:    field = 8'h01;
            4'd2:    field = 8'h03;
            4'd4:    field = 8'h0f;
            default: field = 8'hff;
        endcase
    end

    assign mask = field << bit_pos;

    // ========================================
    // Insert
    // ========================================
    // Neighbouring pixels in the byte pass through untouched
    assign new_byte = (old_byte & ~mask) | ((color & field) << bit_pos);

    // ========================================
    // Extract
    // ========================================
    assign pixel = (old_byte >> bit_pos) & field;    // Zero-extended

endmodule

/* rtl/gfx_pkg.sv */
package gfx_pkg;

    // ========================================
    // Widths
    // ========================================
    localparam int COORD_W    = 16;
    localparam int MEM_ADDR_W = 17;        // 128 KB of video memory
    localparam int PIX_W      = 8;
    localparam int OPCODE_W   = 8;

    localparam logic [MEM_ADDR_W-1:0] PAGE_HALF = 17'd38400;  // Page in a two-page mode
    localparam logic [MEM_ADDR_W-1:0] PAGE_FULL = 17'd76800;  // Whole screen, one page

    // Mode select from mode_control[2:0]
    typedef enum logic [2:0] {
        MODE_640X480_1BPP = 3'b001,
        MODE_640X480_2BPP = 3'b010,
        MODE_320X240_4BPP = 3'b011,
        MODE_320X240_8BPP = 3'b100
    } gfx_mode_e;

    typedef enum logic [OPCODE_W-1:0] {
        OP_WRITE_PIXEL     = 8'h10,
        OP_PIXEL_POS       = 8'h11,
        OP_WRITE_PIXEL_POS = 8'h12,
        OP_CLEAR_SCREEN    = 8'h13,
        OP_GET_PIXEL_AT    = 8'h14
    } gfx_opcode_e;

    typedef struct packed {
        logic [COORD_W-1:0]    width;
        logic [COORD_W-1:0]    height;
        logic [3:0]            bits_per_pixel;   // 1, 2, 4 or 8
        logic                  has_pages;
        logic [MEM_ADDR_W-1:0] page_size;        // Bytes per page
    } mode_cfg_t;

    // Command as assembled by the host from the argument bytes
    typedef struct packed {
        logic [COORD_W-1:0]  x;
        logic [COORD_W-1:0]  y;
        logic [PIX_W-1:0]    color;
        logic [OPCODE_W-1:0] opcode;
    } cmd_t;

    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
        logic [PIX_W-1:0]      wdata;
        logic                  we;
    } mem_req_t;

    // ========================================
    // Mode table
    // ========================================
    function automatic mode_cfg_t lookup_mode_cfg(gfx_mode_e mode);
        mode_cfg_t cfg;
        case (mode)
            MODE_640X480_1BPP: cfg = '{width: 16'd640, height: 16'd480, bits_per_pixel: 4'd1,
                                       has_pages: 1'b1, page_size: PAGE_HALF};
            MODE_640X480_2BPP: cfg = '{width: 16'd640, height: 16'd480, bits_per_pixel: 4'd2,
                                       has_pages: 1'b0, page_size: PAGE_FULL};
            MODE_320X240_4BPP: cfg = '{width: 16'd320, height: 16'd240, bits_per_pixel: 4'd4,
                                       has_pages: 1'b1, page_size: PAGE_HALF};
            MODE_320X240_8BPP: cfg = '{width: 16'd320, height: 16'd240, bits_per_pixel: 4'd8,
                                       has_pages: 1'b0, page_size: PAGE_FULL};
            // Unused codes fall back to 1 bpp without pages
            default:           cfg = '{width: 16'd640, height: 16'd480, bits_per_pixel: 4'd1,
                                       has_pages: 1'b0, page_size: PAGE_HALF};
        endcase
        return cfg;
    endfunction

endpackage

/* sim.f */
rtl/gfx_pkg.sv
rtl/gfx_pixel_addr.sv
rtl/gfx_pixel_merge.sv
rtl/gfx_cursor.sv
rtl/gfx_clear_counter.sv
rtl/gfx_cmd_fsm.sv
rtl/gfx_controller_top.sv
tb/gfx_tb_clock.sv
tb/gfx_controller_checker.sv
tb/gfx_tb.sv

/* tb/gfx_controller_checker.sv */
module gfx_controller_checker (
    input logic              video_clk,
    input logic              reset_n,
    input logic              instruction_start,
    input logic              instruction_busy,
    input logic              instruction_finished,
    input logic              instruction_error,
    input gfx_pkg::mem_req_t mem_req
);

    int failures = 0;    // Number of failed properties

    finish_error_exclusive: assert property (@(posedge video_clk) disable iff (!reset_n)
        !(instruction_finished && instruction_error))
        else begin
            $error("finished and error high in the same cycle");
            failures++;
        end

    // Busy only follows an accepted start
    busy_after_start: assert property (@(posedge video_clk) disable iff (!reset_n)
        $rose(instruction_busy) |-> $past(instruction_start))
        else begin
            $error("busy rose without a start in the previous cycle");
            failures++;
        end

    write_while_busy: assert property (@(posedge video_clk) disable iff (!reset_n)
        mem_req.we |-> instruction_busy)
        else begin
            $error("memory write while busy is low");
            failures++;
        end

    // Writes stay inside the two screen pages
    write_addr_range: assert property (@(posedge video_clk) disable iff (!reset_n)
        mem_req.we |-> (mem_req.addr < gfx_pkg::PAGE_FULL))
        else begin
            $error("memory write address beyond the screen pages");
            failures++;
        end

endmodule

bind gfx_controller_top gfx_controller_checker u_checker (
    .video_clk(video_clk),
    .reset_n(reset_n),
    .instruction_start(instruction_start),
    .instruction_busy(instruction_busy),
    .instruction_finished(instruction_finished),
    .instruction_error(instruction_error),
    .mem_req(mem_req)
);

/* tb/gfx_tb.sv */
module gfx_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int MEM_BYTES    = 1 << gfx_pkg::MEM_ADDR_W;
    localparam int RUN_LEN      = 16;      // Writes per cursor run
    localparam int N_RMW        = 16;
    localparam int N_GET        = 12;
    localparam int MAX_CLEAR    = 76800;   // Largest page in bytes
    localparam int CMD_LIMIT    = MAX_CLEAR + 16;
    localparam int N_CMDS       = 8 * (RUN_LEN + 1) + 3 * N_RMW + 4 * N_GET + 9;
    // 8 cycles per command at worst, two full clears, mode changes, then 50 % margin
    localparam int WATCHDOG_CYCLES = (RESET_CYCLES + 16 + 8 * N_CMDS + 2 * (MAX_CLEAR + 4))
                                     * 3 / 2;

    logic                  video_clk;
    logic                  reset_n;
    logic [7:0]            mode_control;
    gfx_pkg::cmd_t         cmd;
    logic                  instruction_start;
    logic                  instruction_busy;
    logic                  instruction_finished;
    logic                  instruction_error;
    gfx_pkg::mem_req_t     mem_req;
    logic [7:0]            video_data_in = '0;
    logic [7:0]            result_pixel_data;

    logic [7:0]  vram [MEM_BYTES];      // Memory seen by the DUT
    logic [7:0]  shadow [MEM_BYTES];    // Reference copy
    logic [16:0] rd_addr_q = '0;
    logic [31:0] lfsr = 32'h769c_e28c;

    int m_w, m_h, m_bpp, m_psize;       // Current mode in the model
    bit m_pages, m_page;
    int mx = 0;                         // Model cursor
    int my = 0;
    int value_errors = 0;
    int protocol_errors = 0;

    gfx_tb_clock u_clock (.video_clk(video_clk));

    gfx_controller_top uut (
        .video_clk(video_clk),
        .reset_n(reset_n),
        .mode_control(mode_control),
        .cmd(cmd),
        .instruction_start(instruction_start),
        .instruction_busy(instruction_busy),
        .instruction_finished(instruction_finished),
        .instruction_error(instruction_error),
        .mem_req(mem_req),
        .video_data_in(video_data_in),
        .result_pixel_data(result_pixel_data)
    );

    // Registered read, data one edge after the address is taken
    always @(posedge video_clk) begin
        if (mem_req.we) vram[mem_req.addr] <= mem_req.wdata;
        rd_addr_q     <= mem_req.addr;
        video_data_in <= vram[rd_addr_q];
    end

    // ========================================
    // Stimulus and model helpers
    // ========================================
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int rand_below(input int n);
        return int'(lfsr_bits(16)) % n;
    endfunction

    function automatic bit on_screen(input int x, input int y);
        return (x >= 0) && (x < m_w) && (y >= 0) && (y < m_h);
    endfunction

    function automatic int model_addr(input int x, input int y);
        return ((m_pages && m_page) ? m_psize : 0) + (y * m_w + x) / (8 / m_bpp);
    endfunction

    // Low bit of the pixel field, first pixel in the top bits
    function automatic int model_shift(input int x, input int y);
        return 8 - m_bpp * ((y * m_w + x) % (8 / m_bpp) + 1);
    endfunction

    function automatic logic [7:0] model_read(input int x, input int y);
        logic [7:0] field;
        field = 8'((1 << m_bpp) - 1);
        return (shadow[model_addr(x, y)] >> model_shift(x, y)) & field;
    endfunction

    task automatic model_write(input int x, input int y, input logic [7:0] color);
        logic [7:0] field;
        int         a;
        int         sh;
        field     = 8'((1 << m_bpp) - 1);
        a         = model_addr(x, y);
        sh        = model_shift(x, y);
        shadow[a] = (shadow[a] & ~(field << sh)) | ((color & field) << sh);
    endtask

    task automatic set_mode(input int mode, input bit page);
        @(posedge video_clk);
        mode_control <= {3'b000, page, 1'b0, 3'(mode)};
        m_page  = page;
        m_bpp   = 1 << (mode - 1);                   // Modes 1 to 4 hold 1, 2, 4 and 8 bpp
        m_w     = (mode <= 2) ? 640 : 320;
        m_h     = (mode <= 2) ? 480 : 240;
        m_pages = (mode == 1) || (mode == 3);         // Two pages in 1 and 4 bpp
        m_psize = m_w * m_h * m_bpp / 8;              // Bytes in one page
    endtask

    // ========================================
    // One command through model and DUT
    // ========================================
    task automatic exec(input logic [7:0] op, input int x, input int y,
                        input logic [7:0] color, input string name);
        bit         exp_err;
        logic [7:0] exp_pix;
        int         px, py, a, cycles;
        exp_err = 1'b0;
        exp_pix = '0;
        px = (op == gfx_pkg::OP_WRITE_PIXEL) ? mx : x;
        py = (op == gfx_pkg::OP_WRITE_PIXEL) ? my : y;
        case (op)
            gfx_pkg::OP_WRITE_PIXEL, gfx_pkg::OP_WRITE_PIXEL_POS: begin
                if (on_screen(px, py)) begin
                    model_write(px, py, color);
                    mx = (px + 1 < m_w) ? px + 1 : 0;
                    my = (px + 1 < m_w) ? py : ((py + 1 < m_h) ? py + 1 : 0);
                end else exp_err = 1'b1;
            end
            gfx_pkg::OP_PIXEL_POS: begin
                if (on_screen(x, y)) begin
                    mx = x;
                    my = y;
                end else exp_err = 1'b1;
            end
            gfx_pkg::OP_GET_PIXEL_AT: begin
                if (on_screen(x, y)) exp_pix = model_read(x, y);
                else exp_err = 1'b1;
            end
            gfx_pkg::OP_CLEAR_SCREEN: begin
                for (a = model_addr(0, 0); a < model_addr(0, 0) + m_psize; a++) shadow[a] = color;
                mx = 0;    // Cursor goes home
                my = 0;
            end
            default: exp_err = 1'b1;
        endcase

        @(posedge video_clk);
        cmd <= '{x: 16'(x), y: 16'(y), color: color, opcode: op};
        instruction_start <= 1'b1;
        @(posedge video_clk);
        instruction_start <= 1'b0;

        cycles = 0;
        do begin
            @(negedge video_clk);    // Outputs settled mid-cycle
            cycles++;
        end while (!instruction_finished && !instruction_error && cycles < CMD_LIMIT);

        if (!instruction_finished && !instruction_error) begin
            $display("%s: no finished or error pulse within %0d cycles", name, CMD_LIMIT);
            protocol_errors++;
        end else begin
            if (instruction_error !== exp_err) begin
                $display("[ERROR] %s: error flag expected %0b actual %0b",
                         name, exp_err, instruction_error);
                value_errors++;
            end
            if (instruction_busy !== 1'b0) begin
                $display("%s: busy still high when the command ended", name);
                protocol_errors++;
            end
            if (op == gfx_pkg::OP_GET_PIXEL_AT && !exp_err && result_pixel_data !== exp_pix) begin
                $display("[ERROR] %s: pixel (%0d,%0d) expected %02h actual %02h",
                         name, x, y, exp_pix, result_pixel_data);
                value_errors++;
            end
        end
    endtask

    task automatic check_memory(input string name);
        int a;
        int bad;
        bad = 0;
        for (a = 0; a < MEM_BYTES; a++) begin
            if (vram[a] !== shadow[a]) begin
                if (bad < 4) begin
                    $display("[ERROR] %s: byte %05h expected %02h actual %02h",
                             name, a, shadow[a], vram[a]);
                end
                bad++;
            end
        end
        value_errors += bad;
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int         a, m, seg, i, x, y;
        logic [7:0] fill;
        reset_n           = 1'b0;
        mode_control      = '0;
        cmd               = '0;
        instruction_start = 1'b0;
        for (a = 0; a < MEM_BYTES; a++) begin
            vram[a]   = 8'(a ^ (a >> 7) ^ (a >> 13));    // Mixes all address bits
            shadow[a] = vram[a];
        end
        repeat (RESET_CYCLES) @(posedge video_clk);
        reset_n <= 1'b1;

        // Cursor runs across line end and screen end
        for (m = 1; m <= 4; m++) begin
            set_mode(m, lfsr_bits(1) != 0);
            for (seg = 0; seg < 2; seg++) begin
                y = (seg == 0) ? rand_below(m_h - 1) : m_h - 1;
                x = m_w - 1 - rand_below(8);
                exec(gfx_pkg::OP_PIXEL_POS, x, y, 8'h00, "write_run");
                for (i = 0; i < RUN_LEN; i++) begin
                    exec(gfx_pkg::OP_WRITE_PIXEL, 0, 0, 8'(lfsr_bits(8)), "write_run");
                end
            end
            check_memory("write_run");
        end

        for (m = 1; m <= 3; m++) begin
            set_mode(m, lfsr_bits(1) != 0);
            for (i = 0; i < N_RMW; i++) begin
                exec(gfx_pkg::OP_WRITE_PIXEL_POS, rand_below(m_w), rand_below(m_h),
                     8'(lfsr_bits(8)), "rmw_neighbours");
            end
            check_memory("rmw_neighbours");
        end

        for (m = 1; m <= 4; m++) begin
            set_mode(m, lfsr_bits(1) != 0);
            for (i = 0; i < N_GET; i++) begin
                exec(gfx_pkg::OP_GET_PIXEL_AT, rand_below(m_w), rand_below(m_h), 8'h00,
                     "get_pixel");
            end
        end

        // Rejected commands leave memory and cursor alone
        set_mode(3, 1'b0);
        exec(gfx_pkg::OP_PIXEL_POS, 10, 20, 8'h00, "bounds_error");
        exec(gfx_pkg::OP_PIXEL_POS, 320 + rand_below(1000), 5, 8'h00, "bounds_error");
        exec(gfx_pkg::OP_PIXEL_POS, 5, 240 + rand_below(1000), 8'h00, "bounds_error");
        exec(gfx_pkg::OP_WRITE_PIXEL_POS, rand_below(320), 240 + rand_below(500), 8'h0f,
             "bounds_error");
        exec(gfx_pkg::OP_GET_PIXEL_AT, 320, 0, 8'h00, "bounds_error");
        exec(8'h15, 1, 1, 8'h0f, "bad_opcode");
        // Inverted pixel so the write always changes the byte at the cursor
        exec(gfx_pkg::OP_WRITE_PIXEL, 0, 0, ~model_read(mx, my), "bounds_error");
        check_memory("bounds_error");

        for (i = 0; i < 2; i++) begin
            set_mode(1, i == 1);
            fill = 8'(lfsr_bits(8));
            exec(gfx_pkg::OP_CLEAR_SCREEN, 0, 0, fill, "clear_page");
            // Inverted first pixel must land at (0,0)
            exec(gfx_pkg::OP_WRITE_PIXEL, 0, 0, ~model_read(0, 0), "clear_page");
            check_memory("clear_page");
        end

        repeat (2) @(posedge video_clk);
        $display("Errors: %0d value, %0d protocol, %0d assertion",
                 value_errors, protocol_errors, uut.u_checker.failures);
        if (value_errors == 0 && protocol_errors == 0 && uut.u_checker.failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, commands did not complete",
                 WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* tb/gfx_tb_clock.sv */
module gfx_tb_clock (
    output logic video_clk
);

    initial begin
        video_clk = 1'b0;
        forever #2 video_clk = ~video_clk;    // Period of 4
    end

endmodule
